//--- move_gen_pkg.sv
`default_nettype none

package move_gen_pkg;

	localparam int MOVES_PER_LIST = 8;
	localparam int FIFO_DEPTH = 4;

	typedef enum logic [2:0] {
		EMPTY  = 3'd0,
		PAWN   = 3'd1,
		KNIGHT = 3'd2,
		BISHOP = 3'd3,
		ROOK   = 3'd4,
		QUEEN  = 3'd5,
		KING   = 3'd6
	} piece_t;

	typedef enum logic {
		WHITE = 1'b0,
		BLACK = 1'b1
	} side_t;

	typedef struct packed {
		side_t  side;
		piece_t piece;
	} square_t;

	// index is row * 8 + col, square 0 is a1 in the low nibble
	typedef square_t [63:0] board_t;

	typedef struct packed {
		logic [2:0] col;
		logic [2:0] row;
	} coord_t;

	typedef struct packed {
		logic invalid;
		logic promote;
		logic pawn_move;
		logic pawn_double;
		logic en_passant;
		logic castle;
		logic capture;
	} move_flags_t;

	typedef struct packed {
		move_flags_t flags;
		coord_t      from;
		coord_t      to;
	} move_t;

	typedef move_t [0:MOVES_PER_LIST-1] move_list_t; // slot 0 sits in the top bits

	localparam move_t INVALID_MOVE = '{flags: 7'b1000000, from: '0, to: '0};
	localparam move_flags_t CASTLE_FLAGS = 7'b0000010;
	localparam move_flags_t ENP_FLAGS = 7'b0010101; // pawn move, en passant, capture

	localparam logic [5:0] KING_HOME = 6'd4;       // e1
	localparam logic [5:0] ROOK_LEFT_HOME = 6'd0;  // a1
	localparam logic [5:0] ROOK_RIGHT_HOME = 6'd7; // h1
	localparam logic [2:0] ENP_ROW = 3'd4;         // rank 5
	localparam logic [2:0] ENP_TARGET_ROW = 3'd5;  // rank 6

	localparam square_t WHITE_KING = '{side: WHITE, piece: KING};
	localparam square_t WHITE_ROOK = '{side: WHITE, piece: ROOK};
	localparam square_t WHITE_PAWN = '{side: WHITE, piece: PAWN};

	function automatic coord_t coord_of(logic [5:0] index);
		return '{col: index[2:0], row: index[5:3]};
	endfunction

	function automatic logic [5:0] index_of(coord_t c);
		return {c.row, c.col};
	endfunction

	function automatic move_t make_move(move_flags_t flags, coord_t from, coord_t to);
		return '{flags: flags, from: from, to: to};
	endfunction

	// true when any slot carries a real move
	function automatic logic has_move(move_list_t list);
		logic any;
		any = 1'b0;
		for (int i = 0; i < MOVES_PER_LIST; i++)
			any = any | ~list[i].flags.invalid;
		return any;
	endfunction

endpackage

`default_nettype wire

//--- move_list_if.sv
`timescale 1ns/1ps
`default_nettype none

interface move_list_if import move_gen_pkg::*; ();

	logic       push;      // one-cycle write strobe
	move_list_t push_list;
	logic       pop;       // one-cycle read strobe, removes head
	move_list_t pop_list;  // head entry, valid while empty is low
	logic       empty;

	modport producer (
		output push,
		output push_list
	);

	modport buffer (
		input  push,
		input  push_list,
		input  pop,
		output pop_list,
		output empty
	);

	modport consumer (
		output pop,
		input  pop_list,
		input  empty
	);

endinterface

`default_nettype wire

//--- special_move_gen.sv
`timescale 1ns/1ps
`default_nettype none

module special_move_gen import move_gen_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  board_t       board,
	input  logic         castle_left_ok,
	input  logic         castle_right_ok,
	input  logic [7:0]   enp_flags,
	output logic         done,
	move_list_if.producer lists
);

	typedef enum logic [1:0] {
		IDLE,
		CASTLE,
		ENPASSANT,
		FINISHED
	} state_t;

	state_t     state, state_next;
	logic       king_home;
	logic       cas_right, cas_left;
	move_list_t castle_list, enp_list;

	// castling ignores check and attacked squares
	assign king_home = (board[KING_HOME] == WHITE_KING);

	assign cas_right = castle_right_ok && king_home &&
		(board[ROOK_RIGHT_HOME] == WHITE_ROOK) &&
		(board[ROOK_RIGHT_HOME - 6'd1].piece == EMPTY) &&  // g1
		(board[ROOK_RIGHT_HOME - 6'd2].piece == EMPTY);    // f1

	assign cas_left = castle_left_ok && king_home &&
		(board[ROOK_LEFT_HOME] == WHITE_ROOK) &&
		(board[ROOK_LEFT_HOME + 6'd1].piece == EMPTY) &&
		(board[ROOK_LEFT_HOME + 6'd2].piece == EMPTY) &&
		(board[ROOK_LEFT_HOME + 6'd3].piece == EMPTY);

	always_comb begin : castle_build
		for (int i = 0; i < MOVES_PER_LIST; i++)
			castle_list[i] = INVALID_MOVE;
		if (cas_right)
			castle_list[0] = make_move(CASTLE_FLAGS, coord_of(KING_HOME),
				coord_of(KING_HOME + 6'd2)); // e1 to g1
		if (cas_left)
			castle_list[1] = make_move(CASTLE_FLAGS, coord_of(KING_HOME),
				coord_of(KING_HOME - 6'd2)); // e1 to c1
	end

	// one target column per column pair, lower column wins
	always_comb begin : enp_build
		logic [2:0] col_lo;
		logic [2:0] tgt;
		logic       hit;
		coord_t     src, dst;

		for (int i = 0; i < MOVES_PER_LIST; i++)
			enp_list[i] = INVALID_MOVE;

		for (int p = 0; p < MOVES_PER_LIST / 2; p++) begin
			col_lo = 3'(2 * p);
			tgt = col_lo;
			hit = 1'b1;
			if (enp_flags[2*p])
				tgt = col_lo;
			else if (enp_flags[2*p+1])
				tgt = col_lo + 3'd1;
			else
				hit = 1'b0;

			dst = '{col: tgt, row: ENP_TARGET_ROW};

			// capturing pawn from the left neighbour
			src = '{col: tgt - 3'd1, row: ENP_ROW};
			if (hit && tgt != 3'd0 && board[index_of(src)] == WHITE_PAWN)
				enp_list[2*p] = make_move(ENP_FLAGS, src, dst);

			// and from the right neighbour
			src = '{col: tgt + 3'd1, row: ENP_ROW};
			if (hit && tgt != 3'd7 && board[index_of(src)] == WHITE_PAWN)
				enp_list[2*p+1] = make_move(ENP_FLAGS, src, dst);
		end
	end

	always_comb begin
		case (state)
			IDLE:      state_next = CASTLE;
			CASTLE:    state_next = ENPASSANT;
			ENPASSANT: state_next = FINISHED;
			default:   state_next = FINISHED; // hold until the next reset
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= IDLE;
		else
			state <= state_next;
	end

	// a list goes to the fifo only if it holds a move
	assign lists.push = ((state == CASTLE) && has_move(castle_list)) ||
		((state == ENPASSANT) && has_move(enp_list));
	assign lists.push_list = (state == CASTLE) ? castle_list : enp_list;

	assign done = (state == FINISHED);

endmodule

`default_nettype wire

//--- move_list_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module move_list_fifo import move_gen_pkg::*; #(
	parameter type payload_t = move_list_t,
	parameter int  DEPTH = FIFO_DEPTH
) (
	input  logic       clk,
	input  logic       reset,
	move_list_if.buffer lists
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push, do_pop;

	// wrap explicitly so depths that are not a power of two work
	function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign do_push = lists.push && (count != CNT_W'(DEPTH)); // drop writes when full
	assign do_pop = lists.pop && (count != '0);

	assign lists.empty = (count == '0);
	assign lists.pop_list = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= lists.push_list;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

//--- move_unpacker.sv
`timescale 1ns/1ps
`default_nettype none

module move_unpacker import move_gen_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	move_list_if.consumer lists,
	input  logic         rden,
	output move_t        move,
	output logic         empty
);

	localparam int SLOT_W = $clog2(MOVES_PER_LIST);

	move_list_t                cur_list;
	logic [MOVES_PER_LIST-1:0] pending;    // valid slots not yet read
	logic [MOVES_PER_LIST-1:0] valid_mask;
	logic [MOVES_PER_LIST-1:0] taken;
	logic [SLOT_W-1:0]         sel;

	// lowest pending slot is presented first
	always_comb begin : pick_lowest
		sel = '0;
		for (int i = MOVES_PER_LIST - 1; i >= 0; i--) begin
			if (pending[i])
				sel = SLOT_W'(i);
		end
	end

	assign taken = pending & (~pending + 1'b1); // one-hot of lowest set bit

	always_comb begin : list_valid
		for (int i = 0; i < MOVES_PER_LIST; i++)
			valid_mask[i] = ~lists.pop_list[i].flags.invalid;
	end

	assign empty = (pending == '0);

	// fetch the next list only once the current one is drained
	assign lists.pop = empty && !lists.empty;

	assign move = empty ? INVALID_MOVE : cur_list[sel];

	always_ff @(posedge clk) begin
		if (lists.pop)
			cur_list <= lists.pop_list;
	end

	always_ff @(posedge clk) begin
		if (reset)
			pending <= '0;
		else if (lists.pop)
			pending <= valid_mask;
		else if (rden && !empty)
			pending <= pending & ~taken;
	end

endmodule

`default_nettype wire

//--- legal_move_top.sv
`timescale 1ns/1ps
`default_nettype none

module legal_move_top import move_gen_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  board_t     board,
	input  logic       castle_left_ok,
	input  logic       castle_right_ok,
	input  logic [7:0] enp_flags,
	input  logic       rden,
	output move_t      move,
	output logic       empty,
	output logic       done
);

	move_list_if lists_if ();

	// castling and en passant lists for white
	special_move_gen u_gen (
		.clk             (clk),
		.reset           (reset),
		.board           (board),
		.castle_left_ok  (castle_left_ok),
		.castle_right_ok (castle_right_ok),
		.enp_flags       (enp_flags),
		.done            (done),
		.lists           (lists_if)
	);

	move_list_fifo #(
		.payload_t (move_list_t),
		.DEPTH     (FIFO_DEPTH)
	) u_fifo (
		.clk   (clk),
		.reset (reset),
		.lists (lists_if)
	);

	// hands out one move per read strobe
	move_unpacker u_unpack (
		.clk   (clk),
		.reset (reset),
		.lists (lists_if),
		.rden  (rden),
		.move  (move),
		.empty (empty)
	);

endmodule

`default_nettype wire

//--- tb_legal_move.sv
`timescale 1ns/1ps
`default_nettype none

module tb_legal_move import move_gen_pkg::*; ();

	localparam int NUM_CASES = 11;
	localparam int MAX_EXP = 16;
	localparam int READ_WINDOW = 20;  // read-enabled cycles allowed per case
	localparam int QUIET_CYCLES = 8;
	localparam int CYCLE_LIMIT = 60 * NUM_CASES;

	logic       clk;
	logic       reset;
	board_t     board;
	logic       castle_left_ok;
	logic       castle_right_ok;
	logic [7:0] enp_flags;
	logic       rden;
	move_t      move;
	logic       empty;
	logic       done;

	string      case_name [NUM_CASES];
	board_t     case_board [NUM_CASES];
	logic       case_cl [NUM_CASES];
	logic       case_cr [NUM_CASES];
	logic [7:0] case_enp [NUM_CASES];
	logic       case_gaps [NUM_CASES];   // random rden gaps
	logic       case_abort [NUM_CASES];  // reset again before done
	int         case_count [NUM_CASES];
	move_t      case_exp [NUM_CASES][MAX_EXP];

	int          n_cases;
	int          mismatches;
	int          other_errors;
	int          cycles;
	int unsigned rnd;

	legal_move_top UUT (
		.clk             (clk),
		.reset           (reset),
		.board           (board),
		.castle_left_ok  (castle_left_ok),
		.castle_right_ok (castle_right_ok),
		.enp_flags       (enp_flags),
		.rden            (rden),
		.move            (move),
		.empty           (empty),
		.done            (done)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic board_t put_piece(board_t b, int col, int row, side_t s, piece_t p);
		b[row * 8 + col].side = s;
		b[row * 8 + col].piece = p;
		return b;
	endfunction

	// white king on e1 with rooks on a1 and h1
	function automatic board_t home_board();
		board_t b;
		b = '0;
		b = put_piece(b, 4, 0, WHITE, KING);
		b = put_piece(b, 0, 0, WHITE, ROOK);
		b = put_piece(b, 7, 0, WHITE, ROOK);
		return b;
	endfunction

	function automatic move_t castle_move(int to_col);
		move_t m;
		m = '0;
		m.flags.castle = 1'b1;
		m.from.col = 3'd4;  // e1
		m.from.row = 3'd0;
		m.to.col = to_col[2:0];
		m.to.row = 3'd0;
		return m;
	endfunction

	// white pawn on rank 5 takes to rank 6
	function automatic move_t enp_move(int from_col, int to_col);
		move_t m;
		m = '0;
		m.flags.pawn_move = 1'b1;
		m.flags.en_passant = 1'b1;
		m.flags.capture = 1'b1;
		m.from.col = from_col[2:0];
		m.from.row = 3'd4;
		m.to.col = to_col[2:0];
		m.to.row = 3'd5;
		return m;
	endfunction

	task automatic add_case(string name, board_t b, logic cl, logic cr, logic [7:0] enp,
		logic gaps, logic abort);
		case_name[n_cases] = name;
		case_board[n_cases] = b;
		case_cl[n_cases] = cl;
		case_cr[n_cases] = cr;
		case_enp[n_cases] = enp;
		case_gaps[n_cases] = gaps;
		case_abort[n_cases] = abort;
		case_count[n_cases] = 0;
		n_cases++;
	endtask

	task automatic expect_move(move_t m);
		case_exp[n_cases - 1][case_count[n_cases - 1]] = m;
		case_count[n_cases - 1]++;
	endtask

	task automatic build_table();
		board_t b;
		n_cases = 0;
		add_case("castle_both", home_board(), 1'b1, 1'b1, 8'h00, 1'b0, 1'b0);
		expect_move(castle_move(6));
		expect_move(castle_move(2));
		b = put_piece(home_board(), 1, 0, WHITE, KNIGHT);  // b1 blocks the left side
		add_case("castle_right_only", b, 1'b1, 1'b1, 8'h00, 1'b0, 1'b0);
		expect_move(castle_move(6));
		b = put_piece(home_board(), 7, 0, WHITE, EMPTY);   // no rook on h1
		add_case("castle_left_only", b, 1'b1, 1'b1, 8'h00, 1'b0, 1'b0);
		expect_move(castle_move(2));
		add_case("castle_left_flag_off", home_board(), 1'b0, 1'b1, 8'h00, 1'b0, 1'b0);
		expect_move(castle_move(6));
		b = put_piece(home_board(), 4, 4, WHITE, PAWN);
		add_case("no_moves", b, 1'b0, 1'b0, 8'h00, 1'b0, 1'b0);
		b = '0;
		b = put_piece(b, 2, 4, WHITE, PAWN);
		b = put_piece(b, 3, 4, BLACK, PAWN);
		b = put_piece(b, 4, 4, WHITE, PAWN);
		add_case("enp_both_sides", b, 1'b0, 1'b0, 8'h08, 1'b0, 1'b0);
		expect_move(enp_move(2, 3));
		expect_move(enp_move(4, 3));
		// edge columns a and h plus the e and f pair where e is the target
		b = '0;
		b = put_piece(b, 0, 4, BLACK, PAWN);
		b = put_piece(b, 4, 4, BLACK, PAWN);
		b = put_piece(b, 5, 4, BLACK, PAWN);
		b = put_piece(b, 7, 4, BLACK, PAWN);
		b = put_piece(b, 1, 4, WHITE, PAWN);
		b = put_piece(b, 3, 4, WHITE, PAWN);
		b = put_piece(b, 6, 4, WHITE, PAWN);
		add_case("enp_edges_pair", b, 1'b0, 1'b0, 8'hb1, 1'b0, 1'b0);
		expect_move(enp_move(1, 0));
		expect_move(enp_move(3, 4));
		expect_move(enp_move(6, 7));
		b = home_board();
		b = put_piece(b, 1, 4, WHITE, PAWN);
		b = put_piece(b, 2, 4, BLACK, PAWN);
		b = put_piece(b, 3, 4, WHITE, PAWN);
		add_case("castle_then_enp", b, 1'b1, 1'b1, 8'h04, 1'b0, 1'b0);
		expect_move(castle_move(6));
		expect_move(castle_move(2));
		expect_move(enp_move(1, 2));
		expect_move(enp_move(3, 2));
		add_case("back_pressure", b, 1'b1, 1'b1, 8'h04, 1'b1, 1'b0);
		expect_move(castle_move(6));
		expect_move(castle_move(2));
		expect_move(enp_move(1, 2));
		expect_move(enp_move(3, 2));
		add_case("reset_before_done", home_board(), 1'b1, 1'b1, 8'h00, 1'b0, 1'b1);
		b = '0;
		b = put_piece(b, 0, 4, BLACK, PAWN);
		b = put_piece(b, 1, 4, WHITE, PAWN);
		add_case("after_reset", b, 1'b0, 1'b0, 8'h01, 1'b0, 1'b0);
		expect_move(enp_move(1, 0));
	endtask

	// a move seen at the falling edge with rden high is consumed on the next rising edge
	task automatic read_moves(int i);
		int got;
		int active;
		got = 0;
		active = 0;
		while (got < case_count[i] && active < READ_WINDOW) begin
			@(posedge clk);
			if (case_gaps[i])
				rden <= ($urandom % 3) != 0;
			else
				rden <= 1'b1;
			@(negedge clk);
			if (rden) begin
				active++;
				if (empty === 1'b0) begin
					if (move !== case_exp[i][got]) begin
						mismatches++;
						$display("MISMATCH %s move %0d: expected %h, actual %h",
							case_name[i], got, case_exp[i][got], move);
					end
					got++;
				end
			end
		end
		if (got < case_count[i]) begin
			other_errors++;
			$display("%s: only %0d of %0d moves arrived", case_name[i], got, case_count[i]);
		end
		for (int k = 0; k < QUIET_CYCLES; k++) begin
			@(posedge clk);
			rden <= 1'b1;
			@(negedge clk);
			if (empty !== 1'b1) begin
				other_errors++;
				$display("%s: unexpected extra move %h", case_name[i], move);
			end
		end
		@(posedge clk);
		rden <= 1'b0;
	endtask

	task automatic run_case(int i);
		int last_edge;
		int waited;
		last_edge = case_abort[i] ? 2 : 3;
		waited = 0;
		@(posedge clk);
		reset <= 1'b1;
		rden <= 1'b0;
		board <= case_board[i];
		castle_left_ok <= case_cl[i];
		castle_right_ok <= case_cr[i];
		enp_flags <= case_enp[i];
		@(posedge clk);
		@(negedge clk);
		if (done !== 1'b0 || empty !== 1'b1) begin
			other_errors++;
			$display("%s: done or empty still active during reset", case_name[i]);
		end
		@(posedge clk);
		reset <= 1'b0;
		// done belongs on the third edge with reset low
		for (int e = 1; e <= last_edge; e++) begin
			@(posedge clk);
			if (case_abort[i] && e == last_edge)
				reset <= 1'b1;
			@(negedge clk);
			if (e < 3 && done !== 1'b0) begin
				other_errors++;
				$display("%s: done rose early, %0d edges after reset", case_name[i], e);
			end
		end
		if (!case_abort[i]) begin
			if (done !== 1'b1) begin
				other_errors++;
				$display("%s: done did not rise on the third edge after reset", case_name[i]);
				while (done !== 1'b1 && waited < 10) begin
					@(negedge clk);
					waited++;
				end
			end
			if (done === 1'b1)
				read_moves(i);
			else begin
				other_errors++;
				$display("%s: done never rose", case_name[i]);
			end
		end
	endtask

	initial begin
		rnd = $urandom(12716); // seed once
		mismatches = 0;
		other_errors = 0;
		reset = 1'b1;
		board = '0;
		castle_left_ok = 1'b0;
		castle_right_ok = 1'b0;
		enp_flags = 8'h00;
		rden = 1'b0;
		build_table();
		for (int i = 0; i < NUM_CASES; i++)
			run_case(i);
		$display("mismatches: %0d, other errors: %0d", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run still busy after %0d cycles", cycles);
		$display("mismatches: %0d, other errors: %0d", mismatches, other_errors);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
move_gen_pkg.sv
move_list_if.sv
special_move_gen.sv
move_list_fifo.sv
move_unpacker.sv
legal_move_top.sv
tb_legal_move.sv
